/* dual_stream_merge.f */
+incdir+rtl
rtl/stream_merge_pkg.sv
rtl/ram_tp.sv
rtl/ptr_sync.sv
rtl/fifo.sv
rtl/rr_merge.sv
rtl/dual_stream_merge.sv
testbench/dual_stream_merge_sva.sv
testbench/dual_stream_merge_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the stream merger testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module dual_stream_merge_tb \
        -f dual_stream_merge.f -o dual_stream_merge_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/dual_stream_merge_sim +verilator+error+limit+100); then
    echo "$sim_out"
    echo "Simulation exited with an error status"
    exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
echo "Pass message missing from the simulation output"
exit 1

/* testbench/dual_stream_merge_tb.sv */
/* Testbench for the dual-channel stream merger
   Directed tests with one scoreboard per channel, output checked at the falling read edge */
`include "stream_merge_config.svh"

module dual_stream_merge_tb;

    import stream_merge_pkg::*;

    localparam int LIMIT = 5000;                      // Cycles allowed per wait
    localparam int FW    = $clog2(`SM_IN_DEPTH) + 1;

    logic               wr_clk_i    = 1'b0;
    logic               rd_clk_i    = 1'b0;
    logic               wr_rst_n_i  = 1'b1;
    logic               rd_rst_n_i  = 1'b1;
    logic [1:0]         wr_valid_i  = '0;
    in_word_t [1:0]     wr_data_i   = '0;
    logic               out_ready_i = 1'b0;
    logic [1:0]         wr_ready_o;
    logic [1:0][FW-1:0] wr_free_o;
    logic               out_valid_o;
    merge_beat_t        out_beat_o;

    int          seed = 32'h2443_0275;
    int          errors = 0;
    int          failed_tests = 0;
    int          beats = 0;
    int          repeats = 0;      // Words following a word of the same channel
    int          ready_mode = 0;   // 0 low, 1 high, 2 random
    in_word_t    exp_q0 [$];
    in_word_t    exp_q1 [$];
    in_word_t    cur_word;
    chan_id_t    cur_chan;
    logic        expect_hi = 1'b0; // Low half seen, high half next
    logic        have_prev = 1'b0;
    logic        stalled = 1'b0;
    merge_beat_t held;

    always #10 rd_clk_i = ~rd_clk_i;
    always #7 wr_clk_i = ~wr_clk_i;

    dual_stream_merge dual_stream_merge_inst (.*);

    task automatic check_beat(merge_beat_t got, merge_beat_t exp, string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s, got chan %0d hi %0d data %h, expected chan %0d hi %0d data %h",
                     $time, what, got.chan, got.hi_half, got.data,
                     exp.chan, exp.hi_half, exp.data);
            errors++;
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        if (got != exp) begin
            $display("ERROR at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic push_expected(int c, in_word_t w);
        if (c == 0) exp_q0.push_back(w);
        else exp_q1.push_back(w);
    endtask

    // A low half opens a word from its channel's queue, the high half must follow it
    task automatic take_beat(merge_beat_t got);
        merge_beat_t exp;
        beats++;
        if (!expect_hi) begin
            if ((got.chan ? exp_q1.size() : exp_q0.size()) == 0) begin
                $display("ERROR at %0t: beat on channel %0d with no word outstanding",
                         $time, got.chan);
                errors++;
                return;
            end
            if (have_prev && got.chan == cur_chan) repeats++;
            cur_chan  = got.chan;
            have_prev = 1'b1;
            if (got.chan) cur_word = exp_q1.pop_front();
            else cur_word = exp_q0.pop_front();
        end
        exp.chan    = cur_chan;
        exp.hi_half = expect_hi;
        exp.data    = expect_hi ? cur_word[`SM_IN_WIDTH-1:`SM_OUT_WIDTH]
                                : cur_word[`SM_OUT_WIDTH-1:0];
        check_beat(got, exp, "output beat");
        expect_hi = !expect_hi;
    endtask

    // Sets out_ready_i for the coming rising edge, then records the beat that edge takes
    always @(negedge rd_clk_i) begin
        if (stalled) check_beat(out_beat_o, held, "beat during stall");
        case (ready_mode)
            0:       out_ready_i = 1'b0;
            1:       out_ready_i = 1'b1;
            default: out_ready_i = ($random(seed) % 3) != 0;
        endcase
        if (out_valid_o && out_ready_i) take_beat(out_beat_o);
        stalled = rd_rst_n_i && out_valid_o && !out_ready_i;
        held    = out_beat_o;
    end

    task automatic write_words(int c, int n, bit rand_valid);
        int       sent = 0;
        int       guard = 0;
        in_word_t w;
        w = {$random(seed), $random(seed)};
        while (sent < n && guard < LIMIT) begin
            @(negedge wr_clk_i);
            guard++;
            wr_valid_i[c] = !rand_valid || ($random(seed) % 2 == 0);
            wr_data_i[c]  = w;
            if (wr_valid_i[c] && wr_ready_o[c]) begin // Taken at the next rising edge
                push_expected(c, w);
                sent++;
                w = {$random(seed), $random(seed)};
            end
        end
        @(negedge wr_clk_i);
        wr_valid_i[c] = 1'b0;
        if (sent < n) begin
            $display("Timeout: channel %0d accepted only %0d of %0d words", c, sent, n);
            errors++;
        end
    endtask

    task automatic wait_drain();
        int guard = 0;
        while ((exp_q0.size() + exp_q1.size() != 0 || expect_hi) && guard < LIMIT) begin
            @(posedge rd_clk_i);
            guard++;
        end
        if (exp_q0.size() + exp_q1.size() != 0 || expect_hi) begin
            $display("Timeout: output still owes %0d words", exp_q0.size() + exp_q1.size());
            errors++;
        end
    endtask

    task automatic end_test(string name, int errors_before);
        if (errors == errors_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed", name);
            failed_tests++;
        end
    endtask

    task automatic test_reset();
        int e = errors;
        check_count(int'(out_valid_o), 0, "out_valid_o after reset");
        for (int c = 0; c < 2; c++) begin
            check_count(int'(wr_ready_o[c]), 1, "wr_ready_o after reset");
            check_count(int'(wr_free_o[c]), `SM_IN_DEPTH, "wr_free_o after reset");
        end
        end_test("reset state", e);
    endtask

    task automatic test_single();
        int e = errors;
        int b = beats;
        ready_mode = 1;
        write_words(1, 1, 1'b0);
        wait_drain();
        check_count(beats - b, 2, "beats for one word");
        end_test("single word", e);
    endtask

    task automatic test_fill();
        int e = errors;
        int accepted = 0;
        int guard = 0;
        ready_mode = 0;
        @(negedge wr_clk_i);
        while (wr_ready_o[0] && guard < 4 * `SM_IN_DEPTH) begin
            wr_valid_i[0] = 1'b1;
            wr_data_i[0]  = {$random(seed), $random(seed)};
            push_expected(0, wr_data_i[0]);
            accepted++;
            @(negedge wr_clk_i);
            guard++;
        end
        wr_valid_i[0] = 1'b0;
        if (wr_ready_o[0]) begin
            $display("Timeout: wr_ready_o of channel 0 never dropped");
            errors++;
        end
        check_count(accepted, `SM_IN_DEPTH, "words accepted before full");
        check_count(int'(wr_free_o[0]), 0, "wr_free_o when full");
        ready_mode = 1;
        wait_drain();
        guard = 0;
        while (wr_free_o[0] != FW'(`SM_IN_DEPTH) && guard < LIMIT) begin
            @(negedge wr_clk_i);
            guard++;
        end
        if (wr_free_o[0] != FW'(`SM_IN_DEPTH)) begin
            $display("Timeout: wr_free_o of channel 0 never returned to the full depth");
            errors++;
        end
        end_test("fill and drain", e);
    endtask

    // Equal streams on both channels, so the grant must alternate on every word
    task automatic test_both(bit rand_mode, int n, string name);
        int e = errors;
        int b = beats;
        ready_mode = rand_mode ? 2 : 1;
        have_prev  = 1'b0;
        repeats    = 0;
        fork
            write_words(0, n, rand_mode);
            write_words(1, n, rand_mode);
        join
        wait_drain();
        check_count(beats - b, 4 * n, "beats for both channels");
        if (!rand_mode) check_count(repeats, 0, "words that broke alternation");
        end_test(name, e);
    endtask

    initial begin
        int asserts;
        wr_rst_n_i = 1'b0;
        rd_rst_n_i = 1'b0;
        fork
            begin
                repeat (10) @(negedge wr_clk_i);
                wr_rst_n_i = 1'b1;
            end
            begin
                repeat (10) @(negedge rd_clk_i);
                rd_rst_n_i = 1'b1;
            end
        join
        test_reset();
        test_single();
        test_fill();
        test_both(1'b0, 20, "both channels");
        test_both(1'b1, 24, "random back-pressure");
        asserts = dual_stream_merge_inst.dual_stream_merge_sva_inst.assert_fails;
        $display("tests failed: %0d of 5, check errors: %0d, assertion failures: %0d",
                 failed_tests, errors, asserts);
        if (failed_tests == 0 && errors == 0 && asserts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/dual_stream_merge_sva.sv */
/* Assertions on the merged output stream
   Beat stability under back-pressure, reset state and pairing of word halves */
module dual_stream_merge_sva (
    input logic                          rd_clk_i,
    input logic                          rd_rst_n_i,
    input logic                          out_valid_o,
    input logic                          out_ready_i,
    input stream_merge_pkg::merge_beat_t out_beat_o
);

    import stream_merge_pkg::*;

    int       assert_fails = 0;
    logic     lo_taken;  // Low half gone, high half still owed
    chan_id_t lo_chan;

    always_ff @(posedge rd_clk_i or negedge rd_rst_n_i) begin
        if (!rd_rst_n_i) begin
            lo_taken <= 1'b0;
            lo_chan  <= 1'b0;
        end else if (out_valid_o && out_ready_i) begin
            lo_taken <= !out_beat_o.hi_half;
            lo_chan  <= out_beat_o.chan;
        end
    end

    stall_stable_a: assert property (@(posedge rd_clk_i) disable iff (!rd_rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_beat_o))
    else begin
        assert_fails++;
        $error("output beat changed or dropped while stalled");
    end

    reset_idle_a: assert property (@(posedge rd_clk_i) !rd_rst_n_i |-> !out_valid_o)
    else begin
        assert_fails++;
        $error("out_valid_o high during read reset");
    end

    // High half follows on the same channel
    pair_chan_a: assert property (@(posedge rd_clk_i) disable iff (!rd_rst_n_i)
        lo_taken && out_valid_o && out_ready_i |-> out_beat_o.hi_half && out_beat_o.chan == lo_chan)
    else begin
        assert_fails++;
        $error("second half of a word on another channel");
    end

endmodule

bind dual_stream_merge dual_stream_merge_sva dual_stream_merge_sva_inst (
    .rd_clk_i   (rd_clk_i),
    .rd_rst_n_i (rd_rst_n_i),
    .out_valid_o(out_valid_o),
    .out_ready_i(out_ready_i),
    .out_beat_o (out_beat_o)
);

/* rtl/dual_stream_merge.sv */
/* Dual-channel stream merger
   Two clock-crossing FIFOs feeding a round-robin merger */
`include "stream_merge_config.svh"

module dual_stream_merge (
    input  logic                               wr_clk_i,
    input  logic                               wr_rst_n_i,
    input  logic [1:0]                         wr_valid_i,
    input  stream_merge_pkg::in_word_t [1:0]   wr_data_i,
    output logic [1:0]                         wr_ready_o,
    output logic [1:0][$clog2(`SM_IN_DEPTH):0] wr_free_o,

    input  logic                               rd_clk_i,
    input  logic                               rd_rst_n_i,
    input  logic                               out_ready_i,
    output logic                               out_valid_o,
    output stream_merge_pkg::merge_beat_t      out_beat_o
);

    import stream_merge_pkg::*;

    logic [1:0]      fifo_full;
    logic [1:0]      fifo_empty;
    logic [1:0]      fifo_rd_en;
    out_half_t [1:0] fifo_data;

    assign wr_ready_o = ~fifo_full;

    for (genvar c = 0; c < 2; c++) begin : g_chan
        fifo fifo_inst (
            .wr_clk_i  (wr_clk_i),
            .wr_rst_n_i(wr_rst_n_i),
            .wr_en_i   (wr_valid_i[c]),
            .wr_data_i (wr_data_i[c]),
            .wr_full_o (fifo_full[c]),
            .wr_free_o (wr_free_o[c]),
            .rd_clk_i  (rd_clk_i),
            .rd_rst_n_i(rd_rst_n_i),
            .rd_en_i   (fifo_rd_en[c]),
            .rd_data_o (fifo_data[c]),
            .rd_empty_o(fifo_empty[c])
        );
    end

    rr_merge rr_merge_inst (
        .rd_clk_i    (rd_clk_i),
        .rd_rst_n_i  (rd_rst_n_i),
        .fifo_empty_i(fifo_empty),
        .fifo_rd_en_o(fifo_rd_en),
        .fifo_data_i (fifo_data),
        .out_valid_o (out_valid_o),
        .out_beat_o  (out_beat_o),
        .out_ready_i (out_ready_i)
    );

endmodule

/* rtl/rr_merge.sv */
/* Round-robin merger of two half-word FIFOs
   Grants whole words and holds one registered output beat */
module rr_merge (
    input  logic                              rd_clk_i,
    input  logic                              rd_rst_n_i,
    input  logic [1:0]                        fifo_empty_i,
    output logic [1:0]                        fifo_rd_en_o,
    input  stream_merge_pkg::out_half_t [1:0] fifo_data_i,
    output logic                              out_valid_o,
    output stream_merge_pkg::merge_beat_t     out_beat_o,
    input  logic                              out_ready_i
);

    import stream_merge_pkg::*;

    chan_id_t    grant;    // Owner of the word in progress
    chan_id_t    last;     // Channel whose word finished most recently
    logic        half_cnt; // High half is next
    logic        pend;     // Read issued, RAM data arrives this cycle
    logic        valid_q;
    merge_beat_t beat_q;

    chan_id_t sel;
    logic     can_issue;
    logic     issue;

    always_comb begin
        if (half_cnt) begin
            sel = grant; // Never split a word
        end else if (!fifo_empty_i[0] && !fifo_empty_i[1]) begin
            sel = ~last;
        end else begin
            sel = chan_id_t'(fifo_empty_i[0]);
        end
    end

    // One read in flight, and only when the beat slot is free by the next edge
    assign can_issue = (!valid_q || out_ready_i) && !pend;
    assign issue     = can_issue && !fifo_empty_i[sel];

    always_comb begin
        fifo_rd_en_o      = '0;
        fifo_rd_en_o[sel] = issue;
    end

    always_ff @(posedge rd_clk_i or negedge rd_rst_n_i) begin
        if (!rd_rst_n_i) begin
            grant    <= 1'b0;
            last     <= 1'b1; // Channel 0 wins the first tie
            half_cnt <= 1'b0;
            pend     <= 1'b0;
            valid_q  <= 1'b0;
        end else begin
            pend <= issue;
            if (issue) begin
                grant    <= sel;
                half_cnt <= ~half_cnt;
                if (half_cnt) begin
                    last <= sel; // Word complete
                end
            end
            if (pend) begin
                valid_q <= 1'b1;
            end else if (out_ready_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Tags are set at issue, when the old beat is gone or leaving
    always_ff @(posedge rd_clk_i) begin
        if (issue) begin
            beat_q.chan    <= sel;
            beat_q.hi_half <= half_cnt;
        end
        if (pend) begin
            beat_q.data <= fifo_data_i[beat_q.chan];
        end
    end

    assign out_valid_o = valid_q;
    assign out_beat_o  = beat_q;

endmodule

/* rtl/fifo.sv */
/* Asynchronous width-converting FIFO
   Accepts whole words on wr_clk_i and hands out half-words on rd_clk_i */
`include "stream_merge_config.svh"

module fifo (
    input  logic                          wr_clk_i,
    input  logic                          wr_rst_n_i,
    input  logic                          wr_en_i,
    input  stream_merge_pkg::in_word_t    wr_data_i,
    output logic                          wr_full_o,
    output logic [$clog2(`SM_IN_DEPTH):0] wr_free_o,

    input  logic                          rd_clk_i,
    input  logic                          rd_rst_n_i,
    input  logic                          rd_en_i,
    output stream_merge_pkg::out_half_t   rd_data_o,
    output logic                          rd_empty_o
);

    localparam int WA = $clog2(`SM_IN_DEPTH);  // Word address bits
    localparam int RA = $clog2(`SM_OUT_DEPTH); // Half-word address bits

    logic [WA:0] wr_ptr;      // Binary word pointer, write domain
    logic [WA:0] wr_gray;
    logic [WA:0] wr_gray_rd;  // Write pointer as seen by the read domain
    logic [RA:0] wr_ext_gray; // Same, at half-word granularity

    logic [RA:0] rd_ptr;      // Binary half-word pointer, read domain
    logic [RA:0] rd_gray;
    logic [RA:0] rd_gray_wr;  // Read pointer as seen by the write domain
    logic [RA:0] rd_ptr_wr;

    logic wr_push;
    logic rd_pop;

    assign wr_push = wr_en_i & ~wr_full_o; // Writes while full are dropped
    assign rd_pop  = rd_en_i & ~rd_empty_o;

    assign wr_gray = wr_ptr ^ (wr_ptr >> 1);
    assign rd_gray = rd_ptr ^ (rd_ptr >> 1);

    // Appending a zero LSB to the binary pointer appends its parity to the gray code
    assign wr_ext_gray = {wr_gray_rd, ^wr_gray_rd};

    // Upper read gray bits are the gray code of the fully read word count
    assign wr_full_o  = (wr_gray == {~rd_gray_wr[RA:RA-1], rd_gray_wr[RA-2:1]});
    assign rd_empty_o = (rd_gray == wr_ext_gray);

    assign wr_free_o = (WA+1)'(`SM_IN_DEPTH) - (wr_ptr - rd_ptr_wr[RA:1]);

    always_ff @(posedge wr_clk_i or negedge wr_rst_n_i) begin
        if (!wr_rst_n_i) begin
            wr_ptr <= '0;
        end else if (wr_push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge rd_clk_i or negedge rd_rst_n_i) begin
        if (!rd_rst_n_i) begin
            rd_ptr <= '0;
        end else if (rd_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Write pointer into the read domain
    ptr_sync #(
        .WIDTH(WA + 1)
    ) ptr_sync_w2r (
        .src_clk_i  (wr_clk_i),
        .src_rst_n_i(wr_rst_n_i),
        .src_ptr_i  (wr_ptr),
        .dst_clk_i  (rd_clk_i),
        .dst_rst_n_i(rd_rst_n_i),
        .dst_gray_o (wr_gray_rd),
        .dst_ptr_o  ()
    );

    // Read pointer back into the write domain
    ptr_sync #(
        .WIDTH(RA + 1)
    ) ptr_sync_r2w (
        .src_clk_i  (rd_clk_i),
        .src_rst_n_i(rd_rst_n_i),
        .src_ptr_i  (rd_ptr),
        .dst_clk_i  (wr_clk_i),
        .dst_rst_n_i(wr_rst_n_i),
        .dst_gray_o (rd_gray_wr),
        .dst_ptr_o  (rd_ptr_wr)
    );

    ram_tp ram_tp_inst (
        .wr_clk_i (wr_clk_i),
        .wr_en_i  (wr_push),
        .wr_addr_i(wr_ptr[WA-1:0]),
        .wr_data_i(wr_data_i),
        .rd_clk_i (rd_clk_i),
        .rd_en_i  (rd_pop),
        .rd_addr_i(rd_ptr[RA-1:0]),
        .rd_data_o(rd_data_o)
    );

endmodule

/* rtl/ptr_sync.sv */
/* Pointer clock crossing
   Gray encoded and registered at the source, synchronized and decoded at the destination */
`include "stream_merge_config.svh"

module ptr_sync #(
    parameter int WIDTH = 5
) (
    input  logic             src_clk_i,
    input  logic             src_rst_n_i,
    input  logic [WIDTH-1:0] src_ptr_i,

    input  logic             dst_clk_i,
    input  logic             dst_rst_n_i,
    output logic [WIDTH-1:0] dst_gray_o,
    output logic [WIDTH-1:0] dst_ptr_o
);

    logic [WIDTH-1:0] src_gray_q;                 // Launch flop, source domain
    logic [WIDTH-1:0] sync_q [`SM_SYNC_STAGES];   // Destination synchronizer chain

    always_ff @(posedge src_clk_i or negedge src_rst_n_i) begin
        if (!src_rst_n_i) begin
            src_gray_q <= '0;
        end else begin
            src_gray_q <= src_ptr_i ^ (src_ptr_i >> 1);
        end
    end

    always_ff @(posedge dst_clk_i or negedge dst_rst_n_i) begin
        if (!dst_rst_n_i) begin
            for (int i = 0; i < `SM_SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= src_gray_q;
            for (int i = 1; i < `SM_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign dst_gray_o = sync_q[`SM_SYNC_STAGES-1];

    // Gray to binary, each bit is the parity of the gray bits above it
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            dst_ptr_o[i] = ^(dst_gray_o >> i);
        end
    end

endmodule

/* rtl/ram_tp.sv */
/* Two-clock two-port RAM
   Wide write port stores a whole word, narrow read port returns one half through a register */
`include "stream_merge_config.svh"

module ram_tp (
    input  logic                             wr_clk_i,
    input  logic                             wr_en_i,
    input  logic [$clog2(`SM_IN_DEPTH)-1:0]  wr_addr_i,
    input  stream_merge_pkg::in_word_t       wr_data_i,

    input  logic                             rd_clk_i,
    input  logic                             rd_en_i,
    input  logic [$clog2(`SM_OUT_DEPTH)-1:0] rd_addr_i,
    output stream_merge_pkg::out_half_t      rd_data_o
);

    import stream_merge_pkg::*;

    localparam int RATIO = `SM_IN_WIDTH / `SM_OUT_WIDTH; // Halves per word
    localparam int OW    = `SM_OUT_WIDTH;
    localparam int AW    = $clog2(`SM_OUT_DEPTH);

    out_half_t mem [`SM_OUT_DEPTH]; // Half-word array

    // Low half lands at the even address, so it is read out first
    always_ff @(posedge wr_clk_i) begin
        if (wr_en_i) begin
            for (int i = 0; i < RATIO; i++) begin
                mem[AW'(wr_addr_i * RATIO + i)] <= wr_data_i[i*OW +: OW];
            end
        end
    end

    // Registered read, data valid one cycle after rd_en_i
    always_ff @(posedge rd_clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

/* rtl/stream_merge_pkg.sv */
/* Stream merger types
   Producer word, half-word, channel number and output beat */
`include "stream_merge_config.svh"

package stream_merge_pkg;

    // One word from a producer
    typedef logic [`SM_IN_WIDTH-1:0] in_word_t;

    // One half of a word, as read from a FIFO
    typedef logic [`SM_OUT_WIDTH-1:0] out_half_t;

    typedef logic chan_id_t; // Channel 0 or 1

    // Output beat of the merger
    typedef struct packed {
        chan_id_t  chan;    // Source channel
        logic      hi_half; // Second, upper half of the word
        out_half_t data;
    } merge_beat_t;

endpackage

/* rtl/stream_merge_config.svh */
/* Stream merger configuration
   Word widths, FIFO depths and CDC synchronizer length */
`ifndef STREAM_MERGE_CONFIG_SVH
`define STREAM_MERGE_CONFIG_SVH

// Write side word, one per producer beat
`define SM_IN_WIDTH    64

// Read side half-word
`define SM_OUT_WIDTH   32

// FIFO capacity in written words
`define SM_IN_DEPTH    16

// Same capacity in half-words
`define SM_OUT_DEPTH   32

// Destination flops per pointer crossing
`define SM_SYNC_STAGES 2

`endif
